//--- Makefile
TOP       ?= lsu_tb
FILELIST  ?= filelist.f
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/lsu_ctrl_fsm.sv
//////////////////////////////////////////////////
// control FSM of the load/store unit
// takes one request, runs the AXI4-Lite channels, returns a result
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_ctrl_fsm
	import lsu_pkg::*;
(
	input  logic              clk,
	input  logic              rstn,
	input  logic              req_valid_i,
	input  lsu_req_t          req_i,
	output logic              req_ready_o,
	output logic              rsp_valid_o,
	output lsu_rsp_t          rsp_o,
	input  logic [DATA_W-1:0] wdata_fmt_i,
	input  logic [STRB_W-1:0] wstrb_fmt_i,
	input  logic [DATA_W-1:0] rdata_fmt_i,
	output axi_aw_t           aw_o,
	input  logic              awready_i,
	output axi_w_t            w_o,
	input  logic              wready_i,
	output axi_ar_t           ar_o,
	input  logic              arready_i,
	input  axi_r_t            r_i,
	output logic              rready_o,
	input  axi_b_t            b_i,
	output logic              bready_o,
	output logic              tmr_start_o,
	input  logic              tmr_expired_i,
	output mem_op_e           op_o,
	output logic [1:0]        lane_o,
	output logic [DATA_W-1:0] rword_o
);

	lsu_state_e        state_q;
	lsu_state_e        state_d;
	lsu_req_t          req_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] wstrb_q;
	logic [DATA_W-1:0] rword_q;
	logic              err_q;
	logic              aw_done_q;
	logic              w_done_q;
	logic              is_load;
	logic              accept;
	logic              aw_hs;
	logic              w_hs;
	logic              ar_hs;
	logic              r_hs;
	logic              b_hs;
	logic              addr_done;
	logic              resp_done;

	assign is_load = req_q.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	assign accept  = req_valid_i && req_ready_o;

	// channel valids wait for the delay timer
	assign aw_o.addr  = req_q.addr;
	assign aw_o.valid = (state_q == ST_ADDR) && !is_load && !aw_done_q && tmr_expired_i;
	assign w_o.data   = wdata_q;
	assign w_o.strb   = wstrb_q;
	assign w_o.valid  = (state_q == ST_ADDR) && !is_load && !w_done_q && tmr_expired_i;
	assign ar_o.addr  = req_q.addr;
	assign ar_o.valid = (state_q == ST_ADDR) && is_load && tmr_expired_i;
	assign rready_o   = (state_q == ST_RESP) && is_load && tmr_expired_i;
	assign bready_o   = (state_q == ST_RESP) && !is_load && tmr_expired_i;

	assign aw_hs = aw_o.valid && awready_i;
	assign w_hs  = w_o.valid && wready_i;
	assign ar_hs = ar_o.valid && arready_i;
	assign r_hs  = r_i.valid && rready_o;
	assign b_hs  = b_i.valid && bready_o;

	// AW and W may finish in either order
	assign addr_done = is_load ? ar_hs : ((aw_done_q || aw_hs) && (w_done_q || w_hs));
	assign resp_done = is_load ? r_hs : b_hs;

	assign tmr_start_o = accept || ((state_q == ST_ADDR) && addr_done);

	assign req_ready_o = (state_q == ST_IDLE);
	assign rsp_valid_o = (state_q == ST_DONE);
	assign rsp_o.rdata = is_load ? rdata_fmt_i : '0;
	assign rsp_o.rd    = req_q.rd;
	assign rsp_o.err   = err_q;

	assign op_o    = req_q.op;
	assign lane_o  = req_q.addr[1:0];
	assign rword_o = rword_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (req_valid_i) state_d = ST_ADDR;
			ST_ADDR: if (addr_done) state_d = ST_RESP;
			ST_RESP: if (resp_done) state_d = ST_DONE;
			ST_DONE: state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			state_q   <= ST_IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			state_q <= state_d;
			if ((state_q == ST_ADDR) && !addr_done) begin
				aw_done_q <= aw_done_q | aw_hs;
				w_done_q  <= w_done_q | w_hs;
			end else begin
				aw_done_q <= 1'b0;
				w_done_q  <= 1'b0;
			end
			if (accept)
				err_q <= 1'b0;
			else if (r_hs)
				err_q <= (r_i.resp == RESP_SLVERR);
			else if (b_hs)
				err_q <= (b_i.resp == RESP_SLVERR);
		end
	end

	// request and read word
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q   <= req_i;
			wdata_q <= wdata_fmt_i;
			wstrb_q <= wstrb_fmt_i;
		end
		if (r_hs)
			rword_q <= r_i.data;
	end

endmodule

//--- design/lsu_data_ram.sv
//////////////////////////////////////////////////
// AXI4-Lite data memory, word addressed
// answers SLVERR above its range, reads there return zero
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_data_ram
	import lsu_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  axi_aw_t aw_i,
	output logic    awready_o,
	input  axi_w_t  w_i,
	output logic    wready_o,
	input  axi_ar_t ar_i,
	output logic    arready_o,
	output axi_r_t  r_o,
	input  logic    rready_i,
	output axi_b_t  b_o,
	input  logic    bready_i
);

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic              aw_full_q;
	logic              w_full_q;
	logic [ADDR_W-1:0] aw_addr_q;
	logic [DATA_W-1:0] w_data_q;
	logic [STRB_W-1:0] w_strb_q;
	logic              r_valid_q;
	logic [DATA_W-1:0] r_data_q;
	logic [1:0]        r_resp_q;
	logic              b_valid_q;
	logic [1:0]        b_resp_q;
	logic              aw_hs;
	logic              w_hs;
	logic              ar_hs;
	logic              wr_fire;
	logic              wr_ok;
	logic              rd_ok;
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;
	logic [STRB_W-1:0] wr_strb;

	// no new write while a response is pending
	assign awready_o = !aw_full_q && !b_valid_q;
	assign wready_o  = !w_full_q && !b_valid_q;
	assign arready_o = !r_valid_q;

	assign aw_hs = aw_i.valid && awready_o;
	assign w_hs  = w_i.valid && wready_o;
	assign ar_hs = ar_i.valid && arready_o;

	// buffered or arriving this cycle
	assign wr_fire = (aw_full_q || aw_hs) && (w_full_q || w_hs);
	assign wr_addr = aw_full_q ? aw_addr_q : aw_i.addr;
	assign wr_data = w_full_q ? w_data_q : w_i.data;
	assign wr_strb = w_full_q ? w_strb_q : w_i.strb;
	assign wr_ok   = wr_addr < RAM_BYTES;
	assign rd_ok   = ar_i.addr < RAM_BYTES;

	assign r_o.data  = r_data_q;
	assign r_o.resp  = r_resp_q;
	assign r_o.valid = r_valid_q;
	assign b_o.resp  = b_resp_q;
	assign b_o.valid = b_valid_q;

	always_ff @(posedge clk) begin
		if (rstn) begin
			aw_full_q <= 1'b0;
			w_full_q  <= 1'b0;
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (wr_fire) begin
				aw_full_q <= 1'b0;
				w_full_q  <= 1'b0;
			end else begin
				if (aw_hs) aw_full_q <= 1'b1;
				if (w_hs) w_full_q <= 1'b1;
			end
			if (wr_fire)
				b_valid_q <= 1'b1;
			else if (b_valid_q && bready_i)
				b_valid_q <= 1'b0;
			if (ar_hs)
				r_valid_q <= 1'b1;
			else if (r_valid_q && rready_i)
				r_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs) aw_addr_q <= aw_i.addr;
		if (w_hs) begin
			w_data_q <= w_i.data;
			w_strb_q <= w_i.strb;
		end
		if (wr_fire)
			b_resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		if (ar_hs) begin
			r_data_q <= rd_ok ? mem[ar_i.addr[RAM_IDX_W+1:2]] : '0;
			r_resp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// strobed byte write
	always_ff @(posedge clk) begin
		if (wr_fire && wr_ok) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (wr_strb[i])
					mem[wr_addr[RAM_IDX_W+1:2]][8*i +: 8] <= wr_data[8*i +: 8];
			end
		end
	end

endmodule

//--- design/lsu_delay_timer.sv
//////////////////////////////////////////////////
// pseudo-random channel delay for the control FSM
// start loads a count, expired rises when it runs out
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_delay_timer
	import lsu_pkg::*;
(
	input  logic clk,
	input  logic rstn,
	input  logic start_i,
	output logic expired_o
);

	logic [DLY_W-1:0] lfsr_q;
	logic [DLY_W-1:0] cnt_q;

	// galois lfsr, free running
	always_ff @(posedge clk) begin
		if (rstn)
			lfsr_q <= LFSR_SEED;
		else
			lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : '0);
	end

	always_ff @(posedge clk) begin
		if (rstn)
			cnt_q <= '0;
		else if (start_i)
			cnt_q <= lfsr_q;
		else if (cnt_q != '0)
			cnt_q <= cnt_q - 1'b1;
	end

	// stays high until the next start
	assign expired_o = (cnt_q == '0);

endmodule

//--- design/lsu_load_format.sv
//////////////////////////////////////////////////
// load data extraction
// picks the addressed byte or halfword and extends it
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_load_format
	import lsu_pkg::*;
(
	input  mem_op_e           op_i,
	input  logic [1:0]        lane_i,
	input  logic [DATA_W-1:0] rword_i,
	output logic [DATA_W-1:0] rdata_o
);

	logic [DATA_W-1:0] shifted;

	// addressed lane down to bit 0
	assign shifted = rword_i >> {lane_i, 3'b000};

	always_comb begin
		case (op_i)
			OP_LB:   rdata_o = {{24{shifted[7]}}, shifted[7:0]};
			OP_LH:   rdata_o = {{16{shifted[15]}}, shifted[15:0]};
			OP_LBU:  rdata_o = {24'b0, shifted[7:0]};
			OP_LHU:  rdata_o = {16'b0, shifted[15:0]};
			default: rdata_o = rword_i;
		endcase
	end

endmodule

//--- design/lsu_pkg.sv
//////////////////////////////////////////////////
// shared types and constants of the load/store unit
// imported by every design module and the testbench
//////////////////////////////////////////////////
package lsu_pkg;

	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int STRB_W    = 4;
	localparam int TAG_W     = 5;
	localparam int RAM_WORDS = 256;
	localparam int RAM_IDX_W = $clog2(RAM_WORDS);
	localparam logic [ADDR_W-1:0] RAM_BYTES = ADDR_W'(RAM_WORDS * STRB_W);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// delay timer lfsr, x^4 + x^3 + 1
	localparam int         DLY_W     = 4;
	localparam logic [3:0] LFSR_TAPS = 4'b1100;
	localparam logic [3:0] LFSR_SEED = 4'b0001;

	typedef enum logic [3:0] {
		OP_LB  = 4'd0,
		OP_LH  = 4'd1,
		OP_LW  = 4'd2,
		OP_LBU = 4'd3,
		OP_LHU = 4'd4,
		OP_SB  = 4'd5,
		OP_SH  = 4'd6,
		OP_SW  = 4'd7
	} mem_op_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_ADDR = 2'd1,
		ST_RESP = 2'd2,
		ST_DONE = 2'd3
	} lsu_state_e;

	typedef struct packed {
		mem_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [TAG_W-1:0]  rd;
	} lsu_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic [TAG_W-1:0]  rd;
		logic              err;
	} lsu_rsp_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              valid;
	} axi_aw_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              valid;
	} axi_ar_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic              valid;
	} axi_w_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic              valid;
	} axi_r_t;

	typedef struct packed {
		logic [1:0] resp;
		logic       valid;
	} axi_b_t;

endpackage

//--- design/lsu_store_format.sv
//////////////////////////////////////////////////
// store lane formatting
// replicates store data across lanes and builds the byte strobe
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_store_format
	import lsu_pkg::*;
(
	input  mem_op_e           op_i,
	input  logic [1:0]        lane_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] wdata_o,
	output logic [STRB_W-1:0] wstrb_o
);

	always_comb begin
		case (op_i)
			OP_SB: begin
				wdata_o = {4{wdata_i[7:0]}};
				wstrb_o = 4'b0001 << lane_i;
			end
			OP_SH: begin
				// halfword lane from bit 1 only
				wdata_o = {2{wdata_i[15:0]}};
				wstrb_o = 4'b0011 << {lane_i[1], 1'b0};
			end
			OP_SW: begin
				wdata_o = wdata_i;
				wstrb_o = 4'b1111;
			end
			default: begin
				wdata_o = wdata_i;
				wstrb_o = '0;
			end
		endcase
	end

endmodule

//--- design/lsu_top.sv
//////////////////////////////////////////////////
// load/store unit with its AXI4-Lite data RAM
// only the pipeline side is visible at this level
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_top
	import lsu_pkg::*;
(
	input  logic     clk,
	input  logic     rstn,
	input  logic     req_valid_i,
	input  lsu_req_t req_i,
	output logic     req_ready_o,
	output logic     rsp_valid_o,
	output lsu_rsp_t rsp_o
);

	axi_aw_t           aw;
	axi_w_t            w;
	axi_ar_t           ar;
	axi_r_t            r;
	axi_b_t            b;
	logic              awready;
	logic              wready;
	logic              arready;
	logic              rready;
	logic              bready;
	logic              tmr_start;
	logic              tmr_expired;
	mem_op_e           op;
	logic [1:0]        lane;
	logic [DATA_W-1:0] rword;
	logic [DATA_W-1:0] wdata_fmt;
	logic [STRB_W-1:0] wstrb_fmt;
	logic [DATA_W-1:0] rdata_fmt;

	lsu_ctrl_fsm ctrl_fsm_i (
		.clk(clk), .rstn(rstn),
		.req_valid_i(req_valid_i), .req_i(req_i), .req_ready_o(req_ready_o),
		.rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o),
		.wdata_fmt_i(wdata_fmt), .wstrb_fmt_i(wstrb_fmt), .rdata_fmt_i(rdata_fmt),
		.aw_o(aw), .awready_i(awready), .w_o(w), .wready_i(wready),
		.ar_o(ar), .arready_i(arready), .r_i(r), .rready_o(rready),
		.b_i(b), .bready_o(bready),
		.tmr_start_o(tmr_start), .tmr_expired_i(tmr_expired),
		.op_o(op), .lane_o(lane), .rword_o(rword)
	);

	lsu_delay_timer delay_timer_i (
		.clk(clk), .rstn(rstn), .start_i(tmr_start), .expired_o(tmr_expired)
	);

	// store side formats the incoming request, registered at accept
	lsu_store_format store_format_i (
		.op_i(req_i.op), .lane_i(req_i.addr[1:0]), .wdata_i(req_i.wdata),
		.wdata_o(wdata_fmt), .wstrb_o(wstrb_fmt)
	);

	lsu_load_format load_format_i (
		.op_i(op), .lane_i(lane), .rword_i(rword), .rdata_o(rdata_fmt)
	);

	lsu_data_ram data_ram_i (
		.clk(clk), .rstn(rstn),
		.aw_i(aw), .awready_o(awready), .w_i(w), .wready_o(wready),
		.ar_i(ar), .arready_o(arready), .r_o(r), .rready_i(rready),
		.b_o(b), .bready_i(bready)
	);

endmodule

//--- filelist.f
design/lsu_pkg.sv
design/lsu_delay_timer.sv
design/lsu_store_format.sv
design/lsu_load_format.sv
design/lsu_data_ram.sv
design/lsu_ctrl_fsm.sv
design/lsu_top.sv
sim/lsu_asserts.sv
sim/lsu_tb.sv

//--- sim/lsu_asserts.sv
//////////////////////////////////////////////////
// AXI4-Lite and pipeline handshake assertions
// bound into the control FSM from the testbench
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_asserts
	import lsu_pkg::*;
(
	input logic       clk,
	input logic       rstn,
	input lsu_state_e state_i,
	input axi_aw_t    aw_i,
	input logic       awready_i,
	input axi_w_t     w_i,
	input logic       wready_i,
	input axi_ar_t    ar_i,
	input logic       arready_i,
	input axi_r_t     r_i,
	input logic       rready_i,
	input axi_b_t     b_i,
	input logic       bready_i,
	input logic       req_ready_i,
	input logic       rsp_valid_i
);

	// a raised valid holds with its payload until the beat transfers
	aw_stable: assert property (@(posedge clk) disable iff (rstn)
		aw_i.valid && !awready_i |=> aw_i.valid && $stable(aw_i.addr))
		else $error("AW valid or address changed before handshake");

	w_stable: assert property (@(posedge clk) disable iff (rstn)
		w_i.valid && !wready_i |=> w_i.valid && $stable(w_i.data) && $stable(w_i.strb))
		else $error("W valid or payload changed before handshake");

	ar_stable: assert property (@(posedge clk) disable iff (rstn)
		ar_i.valid && !arready_i |=> ar_i.valid && $stable(ar_i.addr))
		else $error("AR valid or address changed before handshake");

	r_stable: assert property (@(posedge clk) disable iff (rstn)
		r_i.valid && !rready_i |=> r_i.valid && $stable(r_i.data) && $stable(r_i.resp))
		else $error("R valid or payload changed before handshake");

	b_stable: assert property (@(posedge clk) disable iff (rstn)
		b_i.valid && !bready_i |=> b_i.valid && $stable(b_i.resp))
		else $error("B valid or response changed before handshake");

	// a busy unit only becomes ready again after its response pulse
	ready_only_idle: assert property (@(posedge clk) disable iff (rstn)
		state_i != ST_IDLE && !rsp_valid_i |=> !req_ready_i)
		else $error("request ready returned before the response");

	// one response pulse per operation
	rsp_one_cycle: assert property (@(posedge clk) disable iff (rstn)
		rsp_valid_i |=> !rsp_valid_i)
		else $error("response valid longer than one cycle");

endmodule

//--- sim/lsu_tb.sv
//////////////////////////////////////////////////
// testbench for the load/store unit and its data RAM
// random loads and stores checked against a byte-array model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_tb
	import lsu_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYC  = 8;
	localparam int N_OPS      = 300;
	localparam int N_INIT     = 32;
	localparam int CYC_PER_OP = 40;
	localparam int MAX_CYCLES = N_OPS * CYC_PER_OP + RESET_CYC;
	localparam int REF_BYTES  = RAM_WORDS * STRB_W;
	localparam int REF_IDX_W  = $clog2(REF_BYTES);

	logic     clk;
	logic     rstn;
	logic     req_valid_i;
	lsu_req_t req_i;
	logic     req_ready_o;
	logic     rsp_valid_o;
	lsu_rsp_t rsp_o;

	logic [7:0]  ref_mem [REF_BYTES];
	logic [15:0] lfsr_state;
	lsu_rsp_t    exp_q [$];
	int          errors;
	int          n_rsp;
	int          cycles;
	logic        busy;

	lsu_top lsu_top_i (
		.clk(clk), .rstn(rstn),
		.req_valid_i(req_valid_i), .req_i(req_i), .req_ready_o(req_ready_o),
		.rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o)
	);

	bind lsu_ctrl_fsm lsu_asserts asserts_i (
		.clk(clk), .rstn(rstn), .state_i(state_q),
		.aw_i(aw_o), .awready_i(awready_i), .w_i(w_o), .wready_i(wready_i),
		.ar_i(ar_o), .arready_i(arready_i), .r_i(r_i), .rready_i(rready_o),
		.b_i(b_i), .bready_i(bready_o),
		.req_ready_i(req_ready_o), .rsp_valid_i(rsp_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// 16-bit galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return bits;
	endfunction

	// expected response from the byte array model
	function automatic lsu_rsp_t ref_access(input lsu_req_t req);
		lsu_rsp_t             rsp;
		logic [REF_IDX_W-1:0] a;
		logic [15:0]          h;
		rsp.rd    = req.rd;
		rsp.rdata = '0;
		rsp.err   = 1'b0;
		a         = req.addr[REF_IDX_W-1:0];
		if (req.addr >= 32'(REF_BYTES)) begin
			rsp.err = 1'b1;
		end else begin
			case (req.op)
				OP_SB: ref_mem[a] = req.wdata[7:0];
				OP_SH: begin
					ref_mem[a]                  = req.wdata[7:0];
					ref_mem[a + REF_IDX_W'(1)] = req.wdata[15:8];
				end
				OP_SW: begin
					for (int i = 0; i < 4; i++)
						ref_mem[a + REF_IDX_W'(i)] = req.wdata[8*i +: 8];
				end
				OP_LB:  rsp.rdata = {{24{ref_mem[a][7]}}, ref_mem[a]};
				OP_LBU: rsp.rdata = {24'b0, ref_mem[a]};
				OP_LH: begin
					h = {ref_mem[a + REF_IDX_W'(1)], ref_mem[a]};
					rsp.rdata = {{16{h[15]}}, h};
				end
				OP_LHU: rsp.rdata = {16'b0, ref_mem[a + REF_IDX_W'(1)], ref_mem[a]};
				OP_LW: rsp.rdata = {ref_mem[a + REF_IDX_W'(3)], ref_mem[a + REF_IDX_W'(2)],
					ref_mem[a + REF_IDX_W'(1)], ref_mem[a]};
			endcase
		end
		return rsp;
	endfunction

	// tested words sit at word index {k, 3'b111} up to the last RAM word
	function automatic lsu_req_t make_init_req(input int k);
		lsu_req_t req;
		req.op    = OP_SW;
		req.addr  = {22'b0, 5'(k), 3'b111, 2'b00};
		req.wdata = take_bits(32);
		req.rd    = 5'(take_bits(5));
		return req;
	endfunction

	function automatic lsu_req_t make_req();
		lsu_req_t   req;
		logic [1:0] lane;
		logic       far;
		req.op = mem_op_e'(4'(take_bits(3)));
		far    = (take_bits(4) == 32'd0);
		lane   = 2'(take_bits(2));
		// aligned to the access size
		case (req.op)
			OP_LH, OP_LHU, OP_SH: lane[0] = 1'b0;
			OP_LW, OP_SW:         lane = 2'b00;
			default:              ;
		endcase
		if (far)
			req.addr = 32'h400 | {20'b0, 10'(take_bits(10)), lane};
		else
			req.addr = {22'b0, 5'(take_bits(5)), 3'b111, lane};
		req.wdata = take_bits(32);
		req.rd    = 5'(take_bits(5));
		return req;
	endfunction

	task automatic check_rsp(input lsu_rsp_t expected, input lsu_rsp_t actual);
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t: rsp %h/%0d/%b, expected %h/%0d/%b", $time,
				actual.rdata, actual.rd, actual.err,
				expected.rdata, expected.rd, expected.err);
		end
	endtask

	task automatic check_ready(input logic expected, input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t: req_ready_o %b, expected %b", $time, actual, expected);
		end
	endtask

	// called on a falling edge and returns after the accepting edge
	task automatic issue(input lsu_req_t req);
		exp_q.push_back(ref_access(req));
		req_i       = req;
		req_valid_i = 1'b1;
		while (!req_ready_o)
			@(negedge clk);
		@(negedge clk);
		req_valid_i = 1'b0;
	endtask

	initial begin
		rstn        = 1'b1;
		req_valid_i = 1'b0;
		req_i       = '0;
		lfsr_state  = 16'd87;
		errors      = 0;
		n_rsp       = 0;
		busy        = 1'b0;
		repeat (RESET_CYC) @(negedge clk);
		rstn = 1'b0;
		for (int k = 0; k < N_INIT; k++)
			issue(make_init_req(k));
		for (int i = N_INIT; i < N_OPS; i++)
			issue(make_req());
		while (exp_q.size() != 0)
			@(negedge clk);
		$display("errors: %0d, responses: %0d", errors, n_rsp);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// sampled at the rising edge before registers update
	initial begin
		lsu_rsp_t expected;
		forever begin
			@(posedge clk);
			if (!rstn) begin
				check_ready(!busy, req_ready_o);
				if (rsp_valid_o) begin
					if (!busy || exp_q.size() == 0) begin
						errors++;
						$display("response at %0t without an outstanding request", $time);
					end else begin
						expected = exp_q.pop_front();
						check_rsp(expected, rsp_o);
						n_rsp++;
					end
					busy = 1'b0;
				end
				if (req_valid_i && req_ready_o)
					busy = 1'b1;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles <= MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d responses", cycles, n_rsp);
		$display("test failed");
		$finish;
	end

endmodule
